// ==== logic/lcd_pkg.sv ====
package lcd_pkg;

	// Bus and count widths
	localparam int data_width   = 8;   // One LCD byte
	localparam int nibble_width = 4;   // DB7..DB4 in 4-bit mode
	localparam int period_width = 8;   // Clock period input, ns
	localparam int time_width   = 25;  // Enough for the 15 ms power-on wait

	// LCD bus timing in ns
	localparam logic [time_width-1:0] t_setup_ns      = time_width'(40);    // RS to E rise
	localparam logic [time_width-1:0] t_e_high_ns     = time_width'(230);   // E pulse width
	localparam logic [time_width-1:0] t_hold_ns       = time_width'(10);    // After E fall
	localparam logic [time_width-1:0] t_nibble_gap_ns = time_width'(1000);  // High to low nibble
	localparam logic [time_width-1:0] t_byte_gap_ns   = time_width'(40000); // Command execution

	// Power-on waits in ns
	localparam logic [time_width-1:0] t_power_on_ns = time_width'(15000000); // Vcc settle
	localparam logic [time_width-1:0] t_init1_ns    = time_width'(4100000);  // After first 3
	localparam logic [time_width-1:0] t_init2_ns    = time_width'(100000);   // After second 3
	localparam logic [time_width-1:0] t_init3_ns    = time_width'(40000);    // After third 3 and 2

	// Nibbles of the reset sequence
	localparam logic [nibble_width-1:0] init_nibble_wake = nibble_width'(3); // Function set 8-bit
	localparam logic [nibble_width-1:0] init_nibble_4bit = nibble_width'(2); // Switch to 4-bit

	// Nibble writer phases
	typedef enum logic [1:0] {
		wr_idle,
		wr_setup,   // Data and RS on the bus, E low
		wr_e_high,
		wr_hold     // E low again, data still held
	} writer_state_e;

	// Power-on sequencer
	typedef enum logic [1:0] {
		init_wait_power,
		init_send,      // Request a nibble and wait for its end
		init_wait_gap,
		init_finished
	} init_state_e;

	// Byte sequencer
	typedef enum logic [2:0] {
		ctrl_init,        // Power-on sequencer owns the writer
		ctrl_idle,
		ctrl_high_nibble,
		ctrl_nibble_gap,
		ctrl_low_nibble,
		ctrl_byte_gap
	} ctrl_state_e;

endpackage

// ==== logic/lcd_delay_timer.sv ====
`timescale 1ns/10ps

module lcd_delay_timer (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             start,          // Restart with a new wait
	input  logic [lcd_pkg::time_width-1:0]   target_ns,
	input  logic [lcd_pkg::period_width-1:0] period_clk_ns,
	output logic                             expired         // One cycle when wait is over
);
	import lcd_pkg::*;

	logic [time_width-1:0] sum_ns;   // Elapsed ns since start
	logic [time_width-1:0] sum_next;
	logic [time_width-1:0] target_q;
	logic                  running;

	// Each running cycle counts one clock period
	assign sum_next = sum_ns + time_width'(period_clk_ns);

	// First cycle whose summed period reaches the target
	assign expired = running && (sum_next >= target_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum_ns  <= '0;
			running <= 1'b0;
		end else if (start) begin
			sum_ns  <= '0;   // Start beats a pending expiry
			running <= 1'b1;
		end else if (running) begin
			sum_ns <= sum_next;
			if (expired)
				running <= 1'b0; // Stop, no repeat pulse
		end
	end

	// Wait length for the current run
	always_ff @(posedge clk) begin
		if (start)
			target_q <= target_ns;
	end

endmodule

// ==== logic/lcd_nibble_writer.sv ====
`timescale 1ns/10ps

module lcd_nibble_writer (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [lcd_pkg::period_width-1:0] period_clk_ns,
	input  logic                             start,       // Only while busy is low
	input  logic [lcd_pkg::nibble_width-1:0] nibble,
	input  logic                             rs,
	output logic                             lcd_e,
	output logic [lcd_pkg::nibble_width-1:0] lcd_nibble,
	output logic                             lcd_rs,
	output logic                             busy,
	output logic                             finished     // Last cycle of the hold phase
);
	import lcd_pkg::*;

	writer_state_e         state;
	logic                  timer_start;
	logic [time_width-1:0] timer_target;
	logic                  timer_expired;

	// One timer measures every phase in turn
	lcd_delay_timer i_phase_timer (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (timer_start),
		.target_ns     (timer_target),
		.period_clk_ns (period_clk_ns),
		.expired       (timer_expired)
	);

	// Length of the phase that is about to begin
	always_comb begin
		timer_start  = 1'b0;
		timer_target = t_setup_ns;
		case (state)
			wr_idle: timer_start = start;      // Setup starts with the data
			wr_setup: begin
				timer_start  = timer_expired;
				timer_target = t_e_high_ns;
			end
			wr_e_high: begin
				timer_start  = timer_expired;
				timer_target = t_hold_ns;
			end
			default: timer_start = 1'b0;       // Hold is the last phase
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= wr_idle;
			lcd_e      <= 1'b0;
			lcd_nibble <= '0;
			lcd_rs     <= 1'b0;
		end else begin
			case (state)
				wr_idle: begin
					if (start) begin
						lcd_nibble <= nibble; // Bus stays stable until next start
						lcd_rs     <= rs;
						state      <= wr_setup;
					end
				end
				wr_setup: begin
					if (timer_expired) begin
						lcd_e <= 1'b1;
						state <= wr_e_high;
					end
				end
				wr_e_high: begin
					if (timer_expired) begin
						lcd_e <= 1'b0;        // LCD samples on this falling edge
						state <= wr_hold;
					end
				end
				wr_hold: begin
					if (timer_expired)
						state <= wr_idle;
				end
				default: state <= wr_idle;
			endcase
		end
	end

	assign busy     = (state != wr_idle);
	assign finished = (state == wr_hold) && timer_expired;

endmodule

// ==== logic/lcd_power_on_init.sv ====
`timescale 1ns/10ps

module lcd_power_on_init (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [lcd_pkg::period_width-1:0] period_clk_ns,
	output logic                             send,            // Nibble request pulse
	output logic [lcd_pkg::nibble_width-1:0] send_nibble,
	input  logic                             nibble_finished,
	output logic                             init_done        // Stays high once set
);
	import lcd_pkg::*;

	init_state_e           state;
	logic [1:0]            step;     // Which of the four nibbles
	logic                  issued;   // Entry action of this state already taken
	logic                  timer_start;
	logic [time_width-1:0] timer_target;
	logic [time_width-1:0] gap_ns;
	logic                  timer_expired;

	lcd_delay_timer i_wait_timer (
		.clk           (clk),
		.rst_n         (rst_n),
		.start         (timer_start),
		.target_ns     (timer_target),
		.period_clk_ns (period_clk_ns),
		.expired       (timer_expired)
	);

	// Wait after each nibble, counted from its end
	always_comb begin
		case (step)
			2'd0:    gap_ns = t_init1_ns;
			2'd1:    gap_ns = t_init2_ns;
			default: gap_ns = t_init3_ns; // Third 3 and the final 2
		endcase
	end

	always_comb begin
		timer_start  = 1'b0;
		timer_target = gap_ns;
		case (state)
			init_wait_power: begin
				timer_start  = !issued;        // Kick once out of reset
				timer_target = t_power_on_ns;
			end
			init_send: timer_start = nibble_finished;
			default:   timer_start = 1'b0;
		endcase
	end

	assign send        = (state == init_send) && !issued;
	assign send_nibble = (step == 2'd3) ? init_nibble_4bit : init_nibble_wake;
	assign init_done   = (state == init_finished);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= init_wait_power;
			step   <= 2'd0;
			issued <= 1'b0;
		end else begin
			case (state)
				init_wait_power: begin
					issued <= 1'b1;
					if (timer_expired) begin
						issued <= 1'b0;
						state  <= init_send;
					end
				end
				init_send: begin
					issued <= 1'b1;           // One request per nibble
					if (nibble_finished) begin
						issued <= 1'b0;
						state  <= init_wait_gap;
					end
				end
				init_wait_gap: begin
					if (timer_expired) begin
						if (step == 2'd3) begin
							state <= init_finished;
						end else begin
							step  <= step + 2'd1;
							state <= init_send;
						end
					end
				end
				default: state <= init_finished; // Terminal
			endcase
		end
	end

endmodule

// ==== logic/lcd_controller.sv ====
`timescale 1ns/10ps

module lcd_controller (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [lcd_pkg::period_width-1:0] period_clk_ns,
	input  logic                             rs_in,
	input  logic [lcd_pkg::data_width-1:0]   data_in,
	input  logic                             strobe_in,   // Taken only while ready
	output logic                             lcd_e,
	output logic [lcd_pkg::nibble_width-1:0] lcd_nibble,
	output logic                             lcd_rs,
	output logic                             done,        // End of byte and its gap
	output logic                             ready
);
	import lcd_pkg::*;

	ctrl_state_e             state;
	logic [nibble_width-1:0] data_q;       // Low nibble of the byte in flight
	logic                    rs_q;
	logic                    accept;
	logic                    init_send;
	logic [nibble_width-1:0] init_nibble;
	logic                    init_done;
	logic                    wr_req;
	logic                    wr_start;
	logic [nibble_width-1:0] wr_nibble;
	logic                    wr_rs;
	logic                    wr_busy;
	logic                    wr_finished;
	logic                    gap_start;
	logic [time_width-1:0]   gap_target;
	logic                    gap_expired;

	lcd_power_on_init i_power_on_init (
		.clk             (clk),
		.rst_n           (rst_n),
		.period_clk_ns   (period_clk_ns),
		.send            (init_send),
		.send_nibble     (init_nibble),
		.nibble_finished (wr_finished && (state == ctrl_init)),
		.init_done       (init_done)
	);

	lcd_nibble_writer i_nibble_writer (
		.clk           (clk),
		.rst_n         (rst_n),
		.period_clk_ns (period_clk_ns),
		.start         (wr_start),
		.nibble        (wr_nibble),
		.rs            (wr_rs),
		.lcd_e         (lcd_e),
		.lcd_nibble    (lcd_nibble),
		.lcd_rs        (lcd_rs),
		.busy          (wr_busy),
		.finished      (wr_finished)
	);

	// Nibble gap and byte gap
	lcd_delay_timer i_gap_timer (
		.clk           (clk),
		.rst_n         (rst_n),
		.period_clk_ns (period_clk_ns),
		.start         (gap_start),
		.target_ns     (gap_target),
		.expired       (gap_expired)
	);

	assign accept = (state == ctrl_idle) && strobe_in;
	assign ready  = (state == ctrl_idle);

	// Writer arbitration, init sequencer first, byte path after
	always_comb begin
		if (state == ctrl_init) begin
			wr_req    = init_send;
			wr_nibble = init_nibble;
			wr_rs     = 1'b0;                              // Instruction register
		end else if (state == ctrl_idle) begin
			wr_req    = accept;                            // High nibble straight off the strobe
			wr_nibble = data_in[data_width-1 -: nibble_width];
			wr_rs     = rs_in;
		end else begin
			wr_req    = (state == ctrl_nibble_gap) && gap_expired;
			wr_nibble = data_q;
			wr_rs     = rs_q;
		end
	end

	assign wr_start = wr_req && !wr_busy;

	// Gap timer starts when either nibble ends
	assign gap_start  = wr_finished && ((state == ctrl_high_nibble) || (state == ctrl_low_nibble));
	assign gap_target = (state == ctrl_high_nibble) ? t_nibble_gap_ns : t_byte_gap_ns;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ctrl_init;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ctrl_init:        if (init_done) state <= ctrl_idle;
				ctrl_idle:        if (accept) state <= ctrl_high_nibble;
				ctrl_high_nibble: if (wr_finished) state <= ctrl_nibble_gap;
				ctrl_nibble_gap:  if (gap_expired) state <= ctrl_low_nibble;
				ctrl_low_nibble:  if (wr_finished) state <= ctrl_byte_gap;
				ctrl_byte_gap: begin
					if (gap_expired) begin
						state <= ctrl_idle;
						done  <= 1'b1;   // Same cycle ready comes back
					end
				end
				default: state <= ctrl_init;
			endcase
		end
	end

	// Low nibble and RS captured on the accepted strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			data_q <= data_in[nibble_width-1:0];
			rs_q   <= rs_in;
		end
	end

endmodule

// ==== logic/lcd_hw_top.sv ====
`timescale 1ns/10ps

module lcd_hw_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [lcd_pkg::period_width-1:0] period_clk_ns,  // Stable while running
	input  logic                             rs_in,
	input  logic [lcd_pkg::data_width-1:0]   data_in,
	input  logic                             strobe_in,
	output logic                             lcd_e,
	output logic                             lcd_rs,
	output logic                             lcd_rw,
	output logic [lcd_pkg::nibble_width-1:0] lcd_nibble,
	output logic                             disable_flash,
	output logic                             done,
	output logic                             ready
);

	lcd_controller i_lcd_controller (
		.clk           (clk),
		.rst_n         (rst_n),
		.period_clk_ns (period_clk_ns),
		.rs_in         (rs_in),
		.data_in       (data_in),
		.strobe_in     (strobe_in),
		.lcd_e         (lcd_e),
		.lcd_nibble    (lcd_nibble),
		.lcd_rs        (lcd_rs),
		.done          (done),
		.ready         (ready)
	);

	// Write only, busy flag never read
	assign lcd_rw = 1'b0;

	// Parallel flash shares the data lines, keep it off the bus
	assign disable_flash = 1'b1;

endmodule

// ==== verif/lcd_asserts.sv ====
`timescale 1ns/10ps

module lcd_asserts (
	input logic                             clk,
	input logic                             rst_n,
	input lcd_pkg::ctrl_state_e             state,
	input logic                             lcd_e,
	input logic [lcd_pkg::nibble_width-1:0] lcd_nibble,
	input logic                             lcd_rs,
	input logic                             done,
	input logic                             ready
);
	import lcd_pkg::*;

	int unsigned fail_count = 0; // Read by the testbench

	// LCD may latch any time while E is high
	bus_stable_e_high: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_e |-> $stable(lcd_nibble) && $stable(lcd_rs))
		else begin
			fail_count++;
			$error("nibble or rs moved while E high");
		end

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			fail_count++;
			$error("done longer than one cycle");
		end

	// Nothing user-visible until init ends
	quiet_during_init: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ctrl_init) |-> !done && !ready)
		else begin
			fail_count++;
			$error("done or ready set during init");
		end

	e_low_at_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !lcd_e)
		else begin
			fail_count++;
			$error("lcd_e high in or right after reset");
		end

endmodule

bind lcd_controller lcd_asserts i_lcd_asserts (
	.clk        (clk),
	.rst_n      (rst_n),
	.state      (state),
	.lcd_e      (lcd_e),
	.lcd_nibble (lcd_nibble),
	.lcd_rs     (lcd_rs),
	.done       (done),
	.ready      (ready)
);

// ==== verif/lcd_tb.sv ====
`timescale 1ns/10ps

module lcd_tb;
	import lcd_pkg::*;

	logic                    clk = 1'b0;
	logic                    rst_n;
	logic [period_width-1:0] period_clk_ns;
	logic                    rs_in;
	logic [data_width-1:0]   data_in;
	logic                    strobe_in;
	logic                    lcd_e;
	logic                    lcd_rs;
	logic                    lcd_rw;
	logic [nibble_width-1:0] lcd_nibble;
	logic                    disable_flash;
	logic                    done;
	logic                    ready;

	// Monitor records, one entry per E pulse
	logic [nibble_width-1:0] mon_nibble[$];
	logic                    mon_rs[$];
	longint                  mon_high_ns[$];
	longint                  mon_setup_ns[$];
	longint                  mon_gap_ns[$];    // E fall to next E rise
	longint                  mon_rise_ns[$];   // Since reset release
	longint                  elapsed_ns, setup_acc, high_acc, low_acc;
	longint                  setup_at_rise, gap_at_rise, rise_at;
	logic                    prev_e, prev_rs;
	logic [nibble_width-1:0] prev_nibble;
	int                      done_count = 0;
	int                      mismatches = 0;
	int                      timeouts = 0;
	int unsigned             assert_fails;
	logic [15:0]             lfsr;

	lcd_hw_top i_lcd_hw_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.period_clk_ns (period_clk_ns),
		.rs_in         (rs_in),
		.data_in       (data_in),
		.strobe_in     (strobe_in),
		.lcd_e         (lcd_e),
		.lcd_rs        (lcd_rs),
		.lcd_rw        (lcd_rw),
		.lcd_nibble    (lcd_nibble),
		.disable_flash (disable_flash),
		.done          (done),
		.ready         (ready)
	);

	always #2 clk = ~clk; // 4 ns

	// Bus monitor, times are cycles times the driven period
	always @(posedge clk) begin
		if (!rst_n) begin
			elapsed_ns  = 0;
			setup_acc   = 0;
			high_acc    = 0;
			low_acc     = 0;
			prev_e      = 1'b0;
			prev_rs     = 1'b0;
			prev_nibble = '0;
		end else begin
			if (lcd_nibble !== prev_nibble || lcd_rs !== prev_rs)
				setup_acc = 0; // New data on the bus
			if (lcd_e) begin
				if (!prev_e) begin
					setup_at_rise = setup_acc;
					gap_at_rise   = low_acc;
					rise_at       = elapsed_ns;
					high_acc      = 0;
				end
				high_acc += longint'(period_clk_ns);
			end else begin
				if (prev_e) begin // Falling edge closes the pulse
					mon_nibble.push_back(prev_nibble);
					mon_rs.push_back(prev_rs);
					mon_high_ns.push_back(high_acc);
					mon_setup_ns.push_back(setup_at_rise);
					mon_gap_ns.push_back(gap_at_rise);
					mon_rise_ns.push_back(rise_at);
					low_acc = 0;
				end
				low_acc   += longint'(period_clk_ns);
				setup_acc += longint'(period_clk_ns);
			end
			if (done)
				done_count++;
			elapsed_ns += longint'(period_clk_ns);
			prev_e      = lcd_e;
			prev_rs     = lcd_rs;
			prev_nibble = lcd_nibble;
		end
	end

	// Taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [data_width-1:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			lfsr  = lfsr_next(lfsr); // One step per bit
			value = {value[data_width-2:0], lfsr[0]};
		end
	endtask

	task automatic compare(input string name, input longint expected, input longint actual,
			input bit at_least);
		if (at_least ? (actual < expected) : (actual != expected)) begin
			mismatches++;
			$display("MISMATCH t=%0t %s expected %s%0d actual %0d", $time, name,
				at_least ? ">= " : "", expected, actual);
		end
	endtask

	task automatic wait_ready(input int max_cycles);
		int cycles;
		cycles = 0;
		while (ready !== 1'b1 && cycles < max_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (ready !== 1'b1) begin
			timeouts++;
			$display("ERROR t=%0t ready did not rise within %0d cycles", $time, max_cycles);
		end
	endtask

	// One strobe, optionally with ignored strobes while busy
	task automatic send_byte(input logic rs, input logic [data_width-1:0] data, input bit noisy);
		int cycles;
		int done_before;
		wait_ready(5000);
		done_before = done_count;
		rs_in     = rs;
		data_in   = data;
		strobe_in = 1'b1;
		@(negedge clk);
		strobe_in = 1'b0;
		compare("ready", 0, ready, 0); // Falls after the accepted strobe
		cycles = 0;
		while (done !== 1'b1 && cycles < 5000) begin
			strobe_in = noisy && !ready && (cycles % 5 == 2);
			data_in   = ~data;
			rs_in     = !rs;
			@(negedge clk);
			cycles++;
		end
		strobe_in = 1'b0;
		if (done !== 1'b1) begin
			timeouts++;
			$display("ERROR t=%0t no done pulse within 5000 cycles of the strobe", $time);
		end
		compare("ready", 1, ready, 0); // Same cycle as done
		@(negedge clk);
		compare("done", 0, done, 0);
		compare("done_count", done_before + 1, done_count, 0);
	endtask

	// Two monitor entries must form the byte
	task automatic check_pulses(input int idx, input logic rs, input logic [data_width-1:0] data);
		compare("lcd_nibble", data[7:4], mon_nibble[idx], 0);
		compare("lcd_nibble", data[3:0], mon_nibble[idx+1], 0);
		compare("lcd_rs", rs, mon_rs[idx], 0);
		compare("lcd_rs", rs, mon_rs[idx+1], 0);
		compare("e_high_ns", t_e_high_ns, mon_high_ns[idx], 1);
		compare("e_high_ns", t_e_high_ns, mon_high_ns[idx+1], 1);
		compare("setup_ns", t_setup_ns, mon_setup_ns[idx], 1);
		compare("setup_ns", t_setup_ns, mon_setup_ns[idx+1], 1);
		compare("nibble_gap_ns", t_nibble_gap_ns, mon_gap_ns[idx+1], 1);
	endtask

	task automatic write_and_check(input logic rs, input logic [data_width-1:0] data,
			input bit noisy);
		int base;
		base = mon_nibble.size();
		send_byte(rs, data, noisy);
		compare("e_pulse_count", base + 2, mon_nibble.size(), 0);
		if (mon_nibble.size() >= base + 2)
			check_pulses(base, rs, data);
	endtask

	task automatic test_reset_state();
		compare("lcd_e", 0, lcd_e, 0);
		compare("done", 0, done, 0);
		compare("ready", 0, ready, 0);
		compare("lcd_rw", 0, lcd_rw, 0);
		compare("disable_flash", 1, disable_flash, 0);
	endtask

	task automatic test_init_sequence();
		wait_ready(150000); // About 97k cycles at 200 ns
		compare("init_pulse_count", 4, mon_nibble.size(), 0);
		compare("done_count", 0, done_count, 0);
		if (mon_nibble.size() == 4) begin
			compare("lcd_nibble", init_nibble_wake, mon_nibble[0], 0);
			compare("lcd_nibble", init_nibble_wake, mon_nibble[1], 0);
			compare("lcd_nibble", init_nibble_wake, mon_nibble[2], 0);
			compare("lcd_nibble", init_nibble_4bit, mon_nibble[3], 0);
			foreach (mon_rs[i])
				compare("lcd_rs", 0, mon_rs[i], 0);
			compare("first_rise_ns", t_power_on_ns, mon_rise_ns[0], 1);
			compare("init_gap1_ns", t_init1_ns, mon_gap_ns[1], 1);
			compare("init_gap2_ns", t_init2_ns, mon_gap_ns[2], 1);
			compare("init_gap3_ns", t_init3_ns, mon_gap_ns[3], 1);
		end
	endtask

	task automatic test_fast_clock();
		wait_ready(5000);
		period_clk_ns = 8'd20; // Changed only while idle
		write_and_check(1'b1, 8'h5a, 1'b0);
		write_and_check(1'b0, 8'hc3, 1'b0);
		wait_ready(5000);
		period_clk_ns = 8'd200;
	endtask

	task automatic test_busy_strobes();
		int base_e;
		int base_done;
		int i;
		write_and_check(1'b1, 8'h96, 1'b1);
		base_e    = mon_nibble.size();
		base_done = done_count;
		for (i = 0; i < 50; i++)
			@(negedge clk); // Quiet window, nothing may follow
		compare("e_pulse_count", base_e, mon_nibble.size(), 0);
		compare("done_count", base_done, done_count, 0);
	endtask

	task automatic test_random_stream();
		logic [data_width-1:0] exp_data[$];
		logic                  exp_rs[$];
		logic [data_width-1:0] value;
		logic [data_width-1:0] rs_bit;
		int                    i;
		mon_nibble.delete();
		mon_rs.delete();
		mon_high_ns.delete();
		mon_setup_ns.delete();
		mon_gap_ns.delete();
		mon_rise_ns.delete();
		for (i = 0; i < 20; i++) begin
			take_bits(8, value);
			take_bits(1, rs_bit);
			exp_data.push_back(value);
			exp_rs.push_back(rs_bit[0]);
			send_byte(rs_bit[0], value, 1'b0);
		end
		compare("e_pulse_count", 40, mon_nibble.size(), 0);
		if (mon_nibble.size() == 40)
			for (i = 0; i < 20; i++)
				check_pulses(2 * i, exp_rs[i], exp_data[i]); // Rebuild in order
	endtask

	initial begin
		rst_n         = 1'b0;
		period_clk_ns = 8'd200;
		rs_in         = 1'b0;
		data_in       = '0;
		strobe_in     = 1'b0;
		lfsr          = 16'd16;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_reset_state();
		test_init_sequence();
		write_and_check(1'b1, 8'h4b, 1'b0); // Data register
		write_and_check(1'b0, 8'h28, 1'b0); // Instruction register
		test_fast_clock();
		test_busy_strobes();
		test_random_stream();
		assert_fails = i_lcd_hw_top.i_lcd_controller.i_lcd_asserts.fail_count;
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, assert_fails);
		if (mismatches == 0 && timeouts == 0 && assert_fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
logic/lcd_pkg.sv
logic/lcd_delay_timer.sv
logic/lcd_nibble_writer.sv
logic/lcd_power_on_init.sv
logic/lcd_controller.sv
logic/lcd_hw_top.sv
verif/lcd_asserts.sv
verif/lcd_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_controller

sources:
  - logic/lcd_pkg.sv
  - logic/lcd_delay_timer.sv
  - logic/lcd_nibble_writer.sv
  - logic/lcd_power_on_init.sv
  - logic/lcd_controller.sv
  - logic/lcd_hw_top.sv
  - target: simulation
    files:
      - verif/lcd_asserts.sv
      - verif/lcd_tb.sv
